// File: verilog.f
+incdir+verif
logic/ifu_pkg.sv
logic/ifu_ifc_ctl.sv
logic/ifu_fetch_buf.sv
logic/ifu_aln_ctl.sv
logic/ifu.sv
verif/ifu_tb_mem.sv
verif/ifu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -j 0 --top-module ifu_tb -f verilog.f -Mdir obj_dir \
   && ./obj_dir/Vifu_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: verif/ifu_tb_rules.svh
// LFSR seed shared by the take pattern and the memory latency
localparam logic [31:0] LFSR_SEED = 32'hd87c;

// parcel at halfword h holds h[14:1] on top and 2'b11 on odd 8-byte lines or 2'b01
function automatic logic [15:0] parcel_at(input pc_t h);
   parcel_at = {h[14:1], (h[3] ? 2'b11 : 2'b01)};
endfunction

// bus error window where byte address bits 6 and 9 are both set
function automatic logic fault_line(input pc_t h);
   fault_line = h[6] & h[9];
endfunction

// galois step with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// File: verif/ifu_tb.sv
`timescale 1ns/1ps

module ifu_tb;
   import ifu_pkg::*;
   `include "ifu_tb_rules.svh"

   localparam pc_t RESET_VEC = 31'h4000_0007;   // 0x8000_000e is the last parcel of a line
   localparam int  WAIT_MAX  = 20000;           // cycles allowed per wait

   logic        clk;
   logic        arst_n                   = 1'b0;
   logic        exu_flush_final          = 1'b0;
   pc_t         exu_flush_path_final     = '0;
   logic        dec_tlu_flush_noredir_wb = 1'b0;
   logic        dec_i0_take              = 1'b0;
   logic        fetch_rvalid;
   line_t       fetch_rdata;
   logic        fetch_rerr;
   logic        fetch_req;
   line_addr_t  fetch_addr;
   logic        ifu_i0_valid;
   logic [31:0] ifu_i0_instr;
   pc_t         ifu_i0_pc;
   logic        ifu_i0_pc4;
   logic        ifu_i0_icaf;

   string       test_name = "reset";
   logic        rand_take = 1'b0;               // take from lfsr bits or held high
   logic [31:0] take_lfsr = LFSR_SEED;
   int          consumed  = 0;                  // instructions taken by decode
   pc_t         exp_pc;                         // pc the rule expects next
   logic        stopped;                        // no-redirect flush in force
   logic        flushed_q;                      // flush seen on the last edge
   logic        hold_q;                         // shown but not taken on the last edge
   logic [63:0] hold_val;                       // {valid, pc, instr} held there

   ifu #(.RESET_VEC(RESET_VEC), .FB_DEPTH(4)) dut_i (.*);
   ifu_tb_mem mem_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                    // 8 ns period
   end

   task automatic abort_run();
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string what, input logic [63:0] exp,
                                  input logic [63:0] act);
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      abort_run();
   endtask

   // wait for n more instructions or time out
   task automatic wait_consumed(input int n);
      int target;
      int cycles;
      target = consumed + n;
      cycles = 0;
      while (consumed < target && cycles < WAIT_MAX) begin
         @(posedge clk);
         cycles++;
      end
      if (consumed < target) begin
         $display("timeout in %s: decode got only %0d of %0d instructions",
                  test_name, n - (target - consumed), n);
         abort_run();
      end
   endtask

   // one-cycle flush strobe for a redirect or a stop
   task automatic flush_to(input pc_t target, input logic noredir);
      @(posedge clk);
      exu_flush_final          <= 1'b1;
      exu_flush_path_final     <= target;
      dec_tlu_flush_noredir_wb <= noredir;
      @(posedge clk);
      exu_flush_final          <= 1'b0;
      dec_tlu_flush_noredir_wb <= 1'b0;
   endtask

   always @(posedge clk) begin
      if (rand_take) begin
         dec_i0_take <= take_lfsr[0];
         take_lfsr   <= lfsr_step(take_lfsr);   // one step per bit taken
      end else begin
         dec_i0_take <= 1'b1;
      end
   end

   //**************************************************************************
   // expected stream walked from each start pc
   //**************************************************************************

   always @(posedge clk) begin
      logic [15:0] p0;
      logic [15:0] p1;
      logic        is4;
      logic [33:0] exp_bits;                    // {instr, pc4, icaf}
      logic [33:0] got;
      logic [63:0] shown;
      p0       = parcel_at(exp_pc);
      p1       = parcel_at(exp_pc + 31'd1);     // may sit in the next line
      is4      = &p0[1:0];
      exp_bits = {(is4 ? {p1, p0} : {16'h0000, p0}), is4,
                  fault_line(exp_pc) | (is4 & fault_line(exp_pc + 31'd1))};
      got      = {ifu_i0_instr, ifu_i0_pc4, ifu_i0_icaf};
      shown    = {ifu_i0_valid, ifu_i0_pc, ifu_i0_instr};
      if (!arst_n) begin
         exp_pc    = RESET_VEC;
         stopped   = 1'b0;
         flushed_q = 1'b0;
         hold_q    = 1'b0;
      end else begin
         if (flushed_q || stopped) begin
            assert (!ifu_i0_valid) else report_mismatch("valid after flush", 64'd0, 64'd1);
         end
         if (hold_q) begin
            assert (shown == hold_val) else report_mismatch("held output", hold_val, shown);
         end
         if (ifu_i0_valid && dec_i0_take) begin
            assert (ifu_i0_pc == exp_pc)
               else report_mismatch("pc", 64'(exp_pc), 64'(ifu_i0_pc));
            assert (got == exp_bits)
               else report_mismatch("instr/pc4/icaf", 64'(exp_bits), 64'(got));
            consumed <= consumed + 1;
            exp_pc    = exp_pc + (is4 ? 31'd2 : 31'd1);
         end
         hold_q    = ifu_i0_valid & ~dec_i0_take & ~exu_flush_final;
         hold_val  = shown;
         flushed_q = exu_flush_final;
         if (exu_flush_final) begin
            stopped = dec_tlu_flush_noredir_wb;
            if (!dec_tlu_flush_noredir_wb) begin
               exp_pc = exu_flush_path_final;   // older instructions are gone
            end
         end
      end
   end

   //**************************************************************************
   // stimulus
   //**************************************************************************

   initial begin
      repeat (16) @(posedge clk);
      assert (!fetch_req && !ifu_i0_valid)
         else report_mismatch("outputs in reset", 64'd0, 64'({fetch_req, ifu_i0_valid}));
      arst_n <= 1'b1;
      test_name = "sequential fetch";           // runs through the 0x240 fault window
      wait_consumed(400);
      test_name = "random take";
      rand_take <= 1'b1;
      wait_consumed(300);
      test_name = "odd redirect";
      flush_to(31'h4000_091f, 1'b0);            // 0x8000_123e straddles
      wait_consumed(40);
      flush_to(31'h4000_1001, 1'b0);            // 0x8000_2002
      wait_consumed(40);
      flush_to(31'h4000_0123, 1'b0);            // 0x8000_0246 in the fault window
      wait_consumed(60);
      test_name = "stop and resume";
      flush_to(31'h4000_2000, 1'b1);
      repeat (50) @(posedge clk);
      flush_to(31'h4000_3007, 1'b0);            // 0x8000_600e
      wait_consumed(100);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// File: verif/ifu_tb_mem.sv
`timescale 1ns/1ps

module ifu_tb_mem (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                fetch_req,       // accepted on every edge it is high
   input  ifu_pkg::line_addr_t fetch_addr,
   output logic                fetch_rvalid,    // one strobe per request, in order
   output ifu_pkg::line_t      fetch_rdata,
   output logic                fetch_rerr
);
   import ifu_pkg::*;
   `include "ifu_tb_rules.svh"

   line_addr_t  addr_q [$];                     // requests still to answer
   int          due_q [$];                      // cycle of each answer
   int          cyc;
   int          last_due;                       // keeps answers in order
   logic [31:0] lfsr;

   // whole line from the parcel rule with parcel 0 in the low bits
   function automatic line_t line_data(input line_addr_t a);
      line_data = '0;
      for (int k = 0; k < PARCELS; k++) begin
         line_data[k*PARCEL_W +: PARCEL_W] = parcel_at({a, 2'(k)});
      end
   endfunction

   initial begin
      fetch_rvalid = 1'b0;
      fetch_rdata  = '0;
      fetch_rerr   = 1'b0;
   end

   always @(posedge clk or negedge arst_n) begin
      int lat;
      if (!arst_n) begin
         addr_q.delete();
         due_q.delete();
         cyc          = 0;
         last_due     = 0;
         lfsr         = LFSR_SEED;
         fetch_rvalid <= 1'b0;
      end else begin
         cyc = cyc + 1;
         if (fetch_req) begin
            lat  = 1 + int'(lfsr[0]);           // latency 1 to 4 from two bits
            lfsr = lfsr_step(lfsr);
            lat  = lat + 2 * int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
            last_due = (cyc + lat - 1 > last_due) ? cyc + lat - 1 : last_due + 1;
            addr_q.push_back(fetch_addr);
            due_q.push_back(last_due);
         end
         if (due_q.size() != 0 && due_q[0] == cyc) begin
            fetch_rvalid <= 1'b1;
            fetch_rdata  <= line_data(addr_q[0]);
            fetch_rerr   <= fault_line({addr_q[0], 2'b00});
            void'(addr_q.pop_front());
            void'(due_q.pop_front());
         end else begin
            fetch_rvalid <= 1'b0;
         end
      end
   end

endmodule

// File: logic/ifu.sv
`timescale 1ns/1ps

module ifu #(
   parameter ifu_pkg::pc_t RESET_VEC = 31'h4000_0000,  // 0x8000_0000 as halfword pc
   parameter int           FB_DEPTH  = 4
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                exu_flush_final,
   input  ifu_pkg::pc_t        exu_flush_path_final,
   input  logic                dec_tlu_flush_noredir_wb,
   input  logic                fetch_rvalid,
   input  ifu_pkg::line_t      fetch_rdata,
   input  logic                fetch_rerr,
   input  logic                dec_i0_take,
   output logic                fetch_req,
   output ifu_pkg::line_addr_t fetch_addr,
   output logic                ifu_i0_valid,
   output logic [31:0]         ifu_i0_instr,
   output ifu_pkg::pc_t        ifu_i0_pc,
   output logic                ifu_i0_pc4,
   output logic                ifu_i0_icaf
);
   import ifu_pkg::*;

   localparam int CNT_W = $clog2(FB_DEPTH + 1);

   logic             flush;
   logic             line_wr;
   pc_t              line_pc;
   logic             pop;
   logic             head_valid;
   line_t            head_data;
   pc_t              head_pc;
   logic             head_err;
   logic             next_valid;
   line_t            next_data;
   logic             next_err;
   logic [CNT_W-1:0] fb_count;

   //**************************************************************************
   // fetch control -> fetch buffer -> aligner
   //**************************************************************************

   ifu_ifc_ctl #(
      .RESET_VEC (RESET_VEC),
      .FB_DEPTH  (FB_DEPTH)
   ) ifc (
      .clk                      (clk),
      .arst_n                   (arst_n),
      .exu_flush_final          (exu_flush_final),
      .exu_flush_path_final     (exu_flush_path_final),
      .dec_tlu_flush_noredir_wb (dec_tlu_flush_noredir_wb),
      .fetch_rvalid             (fetch_rvalid),
      .fb_count                 (fb_count),
      .fetch_req                (fetch_req),
      .fetch_addr               (fetch_addr),
      .flush                    (flush),
      .line_wr                  (line_wr),
      .line_pc                  (line_pc)
   );

   ifu_fetch_buf #(
      .FB_DEPTH (FB_DEPTH)
   ) fbuf (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .line_wr     (line_wr),
      .line_pc     (line_pc),
      .fetch_rdata (fetch_rdata),
      .fetch_rerr  (fetch_rerr),
      .pop         (pop),
      .head_valid  (head_valid),
      .head_data   (head_data),
      .head_pc     (head_pc),
      .head_err    (head_err),
      .next_valid  (next_valid),
      .next_data   (next_data),
      .next_err    (next_err),
      .fb_count    (fb_count)
   );

   ifu_aln_ctl aln (
      .clk          (clk),
      .arst_n       (arst_n),
      .flush        (flush),
      .dec_i0_take  (dec_i0_take),
      .head_valid   (head_valid),
      .head_data    (head_data),
      .head_pc      (head_pc),
      .head_err     (head_err),
      .next_valid   (next_valid),
      .next_data    (next_data),
      .next_err     (next_err),
      .pop          (pop),
      .ifu_i0_valid (ifu_i0_valid),
      .ifu_i0_instr (ifu_i0_instr),
      .ifu_i0_pc    (ifu_i0_pc),
      .ifu_i0_pc4   (ifu_i0_pc4),
      .ifu_i0_icaf  (ifu_i0_icaf)
   );

endmodule

// File: logic/ifu_aln_ctl.sv
`timescale 1ns/1ps

module ifu_aln_ctl (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           flush,          // restart on a fresh head
   input  logic           dec_i0_take,    // decode consumes when valid
   input  logic           head_valid,
   input  ifu_pkg::line_t head_data,
   input  ifu_pkg::pc_t   head_pc,
   input  logic           head_err,
   input  logic           next_valid,
   input  ifu_pkg::line_t next_data,
   input  logic           next_err,
   output logic           pop,            // head line fully used
   output logic           ifu_i0_valid,
   output logic [31:0]    ifu_i0_instr,   // upper half zero when compressed
   output ifu_pkg::pc_t   ifu_i0_pc,
   output logic           ifu_i0_pc4,     // 4-byte instruction
   output logic           ifu_i0_icaf     // fetch access fault
);
   import ifu_pkg::*;

   localparam int OFF_W = $clog2(PARCELS);

   logic [OFF_W-1:0]    off_q;            // parcel offset inside the head line
   logic                head_used;        // off_q valid for this head, else use its pc
   logic [OFF_W-1:0]    cur_off;
   logic [OFF_W-1:0]    nxt_off;          // parcel behind cur_off, wraps
   logic [OFF_W:0]      off_sum;          // offset after this instruction
   logic [PARCEL_W-1:0] first_parcel;
   logic [PARCEL_W-1:0] second_parcel;
   logic                is4;
   logic                straddle;         // second parcel sits in the next line
   logic                take;

   //**************************************************************************
   // parcel selection
   //**************************************************************************

   assign cur_off = head_used ? off_q : head_pc[2:1];   // flush target may start mid-line
   assign nxt_off = cur_off + 1'b1;

   assign first_parcel = head_data[cur_off*PARCEL_W +: PARCEL_W];
   assign is4          = &first_parcel[1:0];             // 2'b11 starts a 32-bit instruction
   assign straddle     = is4 & (cur_off == OFF_W'(PARCELS - 1));

   assign second_parcel = straddle ? next_data[PARCEL_W-1:0]
                                   : head_data[nxt_off*PARCEL_W +: PARCEL_W];

   //**************************************************************************
   // decode port
   //**************************************************************************

   assign ifu_i0_valid = head_valid & (~straddle | next_valid);
   assign ifu_i0_instr = is4 ? {second_parcel, first_parcel} : {16'h0000, first_parcel};
   assign ifu_i0_pc    = {head_pc[31:3], cur_off};
   assign ifu_i0_pc4   = is4;
   assign ifu_i0_icaf  = head_err | (straddle & next_err);  // either line used

   assign take    = ifu_i0_valid & dec_i0_take;
   assign off_sum = {1'b0, cur_off} + (is4 ? (OFF_W + 1)'(2) : (OFF_W + 1)'(1));
   assign pop     = take & (off_sum >= (OFF_W + 1)'(PARCELS));  // stepped past last parcel

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         head_used <= 1'b0;
         off_q     <= '0;
      end else if (flush) begin
         head_used <= 1'b0;                    // next head carries the target offset
      end else if (take) begin
         head_used <= ~pop | straddle;         // straddle already used parcel 0 of next line
         off_q     <= off_sum[OFF_W-1:0];
      end
   end

endmodule

// File: logic/ifu_fetch_buf.sv
`timescale 1ns/1ps

module ifu_fetch_buf #(
   parameter int FB_DEPTH = 4                                      // entries
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          flush,                    // drop all entries
   input  logic                          line_wr,                  // push a line
   input  ifu_pkg::pc_t                  line_pc,                  // its pc tag
   input  ifu_pkg::line_t                fetch_rdata,              // its data
   input  logic                          fetch_rerr,               // its bus error
   input  logic                          pop,                      // retire the head
   output logic                          head_valid,
   output ifu_pkg::line_t                head_data,
   output ifu_pkg::pc_t                  head_pc,
   output logic                          head_err,
   output logic                          next_valid,               // entry behind the head
   output ifu_pkg::line_t                next_data,
   output logic                          next_err,
   output logic [$clog2(FB_DEPTH+1)-1:0] fb_count                  // occupied entries
);
   import ifu_pkg::*;

   localparam int CNT_W = $clog2(FB_DEPTH + 1);
   localparam int PTR_W = $clog2(FB_DEPTH);

   line_t             data_q [FB_DEPTH];      // line payload
   pc_t               pc_q   [FB_DEPTH];      // pc tag per line
   logic [FB_DEPTH-1:0] err_q;                // bus error per line
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr_nx;              // second entry for straddling instructions
   logic [CNT_W-1:0]  count;

   // wrap at the depth which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      ptr_inc = (ptr == PTR_W'(FB_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   //**************************************************************************
   // read side
   //**************************************************************************

   assign rd_ptr_nx = ptr_inc(rd_ptr);

   assign head_valid = (count != '0);
   assign head_data  = data_q[rd_ptr];
   assign head_pc    = pc_q[rd_ptr];
   assign head_err   = err_q[rd_ptr];

   assign next_valid = (count > CNT_W'(1));
   assign next_data  = data_q[rd_ptr_nx];
   assign next_err   = err_q[rd_ptr_nx];

   assign fb_count = count;

   //**************************************************************************
   // pointers and storage
   //**************************************************************************

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else if (flush) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (line_wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= rd_ptr_nx;
         end
         count <= count + CNT_W'(line_wr) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (line_wr) begin
         data_q[wr_ptr] <= fetch_rdata;
         pc_q[wr_ptr]   <= line_pc;
         err_q[wr_ptr]  <= fetch_rerr;
      end
   end

endmodule

// File: logic/ifu_ifc_ctl.sv
`timescale 1ns/1ps

module ifu_ifc_ctl #(
   parameter ifu_pkg::pc_t RESET_VEC = 31'h4000_0000,  // first fetch pc in halfword units
   parameter int           FB_DEPTH  = 4               // fetch buffer entries
) (
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          exu_flush_final,          // flush strobe
   input  ifu_pkg::pc_t                  exu_flush_path_final,     // flush target pc
   input  logic                          dec_tlu_flush_noredir_wb, // stop fetch with the flush
   input  logic                          fetch_rvalid,             // one line returned
   input  logic [$clog2(FB_DEPTH+1)-1:0] fb_count,                 // lines held in buffer
   output logic                          fetch_req,                // request strobe
   output ifu_pkg::line_addr_t           fetch_addr,               // line being requested
   output logic                          flush,                    // flush to buffer and aligner
   output logic                          line_wr,                  // keep this response
   output ifu_pkg::pc_t                  line_pc                   // pc tag of kept response
);
   import ifu_pkg::*;

   localparam int CNT_W = $clog2(FB_DEPTH + 1);

   fetch_state_t     state;
   fetch_state_t     state_nxt;
   pc_t              fetch_pc;        // pc of the request on the bus or of the next one
   pc_t              oldest_pc;       // pc of the oldest request still to be kept
   logic [CNT_W-1:0] out_cnt;         // requests issued, response not yet back
   logic [CNT_W-1:0] out_cnt_nxt;
   logic [CNT_W-1:0] discard_cnt;     // responses still to be dropped
   logic [CNT_W:0]   fill_nxt;        // in flight plus buffered after this edge
   logic             redirect;
   logic             discard_rsp;
   logic             fetch_req_nxt;

   // next sequential line with the offset cleared
   function automatic pc_t next_line(input pc_t pc);
      next_line = {pc[31:3], 2'b00} + pc_t'(FETCH_BYTES / 2);  // pc counts halfwords
   endfunction

   //**************************************************************************
   // flush handling and response tagging
   //**************************************************************************

   assign flush    = exu_flush_final;
   assign redirect = exu_flush_final & ~dec_tlu_flush_noredir_wb;

   assign discard_rsp = fetch_rvalid & (discard_cnt != '0);   // stale line from before a flush
   assign line_wr     = fetch_rvalid & ~discard_rsp & ~flush;
   assign line_pc     = oldest_pc;                            // responses come back in order

   assign fetch_addr = fetch_pc[31:3];

   assign state_nxt = flush ? (dec_tlu_flush_noredir_wb ? FETCH_IDLE : FETCH_RUN) : state;

   //**************************************************************************
   // request credit
   //**************************************************************************

   // the strobe is always accepted so a high fetch_req counts on this edge
   assign out_cnt_nxt = out_cnt + CNT_W'(fetch_req) - CNT_W'(fetch_rvalid);

   // pop is ignored here so the credit is conservative by a cycle
   assign fill_nxt = {1'b0, out_cnt_nxt}
                   + (flush ? '0 : ({1'b0, fb_count} + (CNT_W + 1)'(line_wr)));

   assign fetch_req_nxt = (state_nxt == FETCH_RUN) & (fill_nxt < (CNT_W + 1)'(FB_DEPTH));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state       <= FETCH_RUN;
         fetch_req   <= 1'b0;
         fetch_pc    <= RESET_VEC;
         oldest_pc   <= RESET_VEC;
         out_cnt     <= '0;
         discard_cnt <= '0;
      end else begin
         state     <= state_nxt;
         fetch_req <= fetch_req_nxt;                  // first flush-line request next cycle
         out_cnt   <= out_cnt_nxt;

         if (redirect) begin
            fetch_pc <= exu_flush_path_final;         // keeps its halfword offset
         end else if (fetch_req) begin
            fetch_pc <= next_line(fetch_pc);
         end

         if (redirect) begin
            oldest_pc <= exu_flush_path_final;        // first kept response is the target
         end else if (line_wr) begin
            oldest_pc <= next_line(oldest_pc);
         end

         if (flush) begin
            discard_cnt <= out_cnt_nxt;               // everything still in flight is stale
         end else if (discard_rsp) begin
            discard_cnt <= discard_cnt - 1'b1;
         end
      end
   end

endmodule

// File: logic/ifu_pkg.sv
package ifu_pkg;

   //**************************************************************************
   // fetch line and parcel geometry
   //**************************************************************************

   localparam int FETCH_BYTES = 8;                     // bytes per fetch line
   localparam int LINE_W      = FETCH_BYTES * 8;       // bits per fetch line
   localparam int PARCEL_W    = 16;                    // one compressed parcel
   localparam int PARCELS     = LINE_W / PARCEL_W;     // parcels per line

   //**************************************************************************
   // address and data types
   //**************************************************************************

   typedef logic [31:1]       pc_t;                    // halfword pc with bit 0 implied zero
   typedef logic [31:3]       line_addr_t;             // 8-byte line address
   typedef logic [LINE_W-1:0] line_t;                  // one fetch line with parcel 0 low

   // fetch control state
   typedef enum logic {
      FETCH_RUN  = 1'b0,                               // issuing sequential requests
      FETCH_IDLE = 1'b1                                // halted until a redirect flush
   } fetch_state_t;

endpackage
